//--- Bender.yml
package:
  name: prefetch_buffer_tmr

sources:
  - include_dirs:
      - .
    files:
      - prefetch_buffer_tmr_pkg.sv
      - prefetch_buffer_core.sv
      - tmr_voter.sv
      - fault_monitor.sv
      - prefetch_buffer_tmr.sv
  - target: test
    include_dirs:
      - .
    files:
      - prefetch_buffer_tmr_asserts.sv
      - prefetch_buffer_tmr_tb.sv

//--- fault_monitor.sv
/*
 * Per-replica leaky error counters with sticky broken flags.
 * Broken clears only on reset. Error flags are combinational.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module fault_monitor (
        input  logic                               clk,
        input  logic                               rst_i,
        input  prefetch_buffer_tmr_pkg::repl_vec_t out_block_err_i,
        input  prefetch_buffer_tmr_pkg::repl_vec_t req_block_err_i,
        input  logic                               out_detected_i,
        input  logic                               out_corrected_i,
        input  logic                               req_detected_i,
        input  logic                               req_corrected_i,
        input  prefetch_buffer_tmr_pkg::repl_vec_t set_broken_i,
        output prefetch_buffer_tmr_pkg::repl_vec_t is_broken_o,
        output logic                               err_detected_o,
        output logic                               err_corrected_o
);
        import prefetch_buffer_tmr_pkg::*;

        localparam int CNT_W = `FT_COUNT_W;
        localparam logic [CNT_W-1:0] INC     = CNT_W'(`FT_INCREMENT);
        localparam logic [CNT_W-1:0] DEC     = CNT_W'(`FT_DECREMENT);
        localparam logic [CNT_W-1:0] THRESH  = CNT_W'(`FT_THRESHOLD);
        localparam logic [CNT_W-1:0] CNT_MAX = '1;

        repl_vec_t block_err;

        // A replica is at fault if either voter blames it
        assign block_err = out_block_err_i | req_block_err_i;

        assign err_detected_o  = out_detected_i | req_detected_i;
        assign err_corrected_o = out_corrected_i | req_corrected_i;

        ////////////////////////////////////////////////////////////////////////////
        // Breakage counters
        ////////////////////////////////////////////////////////////////////////////

        for (genvar r = 0; r < `PF_N_REPL; r++) begin : g_mon
                logic [CNT_W-1:0] cnt_q;
                logic [CNT_W-1:0] cnt_d;
                logic             broken_q;

                // Saturates at both ends
                always_comb begin
                        if (block_err[r]) begin
                                cnt_d = (cnt_q > CNT_MAX - INC) ? CNT_MAX : cnt_q + INC;
                        end else begin
                                cnt_d = (cnt_q < DEC) ? '0 : cnt_q - DEC;
                        end
                end

                always_ff @(posedge clk) begin
                        if (rst_i) begin
                                cnt_q    <= '0;
                                broken_q <= 1'b0;
                        end else begin
                                cnt_q <= cnt_d;
                                if (set_broken_i[r] || (cnt_d >= THRESH)) begin
                                        broken_q <= 1'b1;
                                end
                        end
                end

                assign is_broken_o[r] = broken_q;
        end

endmodule

//--- prefetch_buffer_core.sv
/*
 * Single prefetch buffer replica on a req/gnt/rvalid memory port.
 * Idle after reset until the first branch supplies a start address.
 * A request waiting for grant is never withdrawn; if a branch hits it,
 * its response is dropped and fetching resumes at the branch target.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module prefetch_buffer_core (
        input  logic                                 clk,
        input  logic                                 rst_i,
        input  prefetch_buffer_tmr_pkg::fetch_ctrl_t fetch_ctrl_i,
        input  prefetch_buffer_tmr_pkg::mem_rsp_t    mem_rsp_i,
        output prefetch_buffer_tmr_pkg::fetch_out_t  fetch_o,
        output prefetch_buffer_tmr_pkg::mem_req_t    mem_req_o
);
        import prefetch_buffer_tmr_pkg::*;

        localparam int DEPTH  = `PF_FIFO_DEPTH;
        localparam int ADDR_W = `PF_ADDR_W;
        localparam int DATA_W = `PF_DATA_W;
        localparam int CNT_W  = $clog2(DEPTH + 1);
        localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
        localparam logic [ADDR_W-1:0] WORD_STEP = ADDR_W'(4);

        // Fetch control state
        logic              active_q;
        logic [ADDR_W-1:0] addr_q;
        logic [ADDR_W-1:0] br_addr_q;
        logic              pend_q;
        logic              stale_q;
        logic [CNT_W-1:0]  out_cnt_q;
        logic [CNT_W-1:0]  out_cnt_d;
        logic [CNT_W-1:0]  disc_cnt_q;
        logic [CNT_W-1:0]  disc_cnt_d;

        // Instruction FIFO
        logic [DATA_W-1:0] fifo_mem [DEPTH];
        logic [CNT_W-1:0]  fifo_cnt_q;
        logic [PTR_W-1:0]  rd_ptr_q;
        logic [PTR_W-1:0]  wr_ptr_q;

        logic branch;
        logic can_issue;
        logic req;
        logic gnt_fire;
        logic push;
        logic pop;
        logic valid;

        function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
                if (int'(ptr) == DEPTH - 1) begin
                        return '0;
                end
                return ptr + PTR_W'(1);
        endfunction

        ////////////////////////////////////////////////////////////////////////////
        // Request side
        ////////////////////////////////////////////////////////////////////////////

        assign branch = fetch_ctrl_i.branch;

        // Room counts stored words and words still in flight
        assign can_issue = active_q && fetch_ctrl_i.req && !branch
                           && (int'(fifo_cnt_q) + int'(out_cnt_q) < DEPTH);

        // Once raised, req holds until granted
        assign req      = pend_q || can_issue;
        assign gnt_fire = req && mem_rsp_i.gnt;

        always_comb begin
                out_cnt_d = out_cnt_q + CNT_W'(gnt_fire) - CNT_W'(mem_rsp_i.rvalid);
                if (branch) begin
                        // Everything still in flight after this cycle is stale
                        disc_cnt_d = out_cnt_d;
                end else begin
                        disc_cnt_d = disc_cnt_q + CNT_W'(gnt_fire && stale_q)
                                     - CNT_W'(mem_rsp_i.rvalid && (disc_cnt_q != '0));
                end
        end

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        active_q   <= 1'b0;
                        addr_q     <= '0;
                        pend_q     <= 1'b0;
                        stale_q    <= 1'b0;
                        out_cnt_q  <= '0;
                        disc_cnt_q <= '0;
                end else begin
                        out_cnt_q  <= out_cnt_d;
                        disc_cnt_q <= disc_cnt_d;
                        pend_q     <= req && !mem_rsp_i.gnt;
                        if (branch) begin
                                active_q <= 1'b1;
                                if (pend_q && !mem_rsp_i.gnt) begin
                                        // Old address stays on the bus until granted
                                        stale_q <= 1'b1;
                                end else begin
                                        addr_q  <= fetch_ctrl_i.branch_addr;
                                        stale_q <= 1'b0;
                                end
                        end else if (gnt_fire) begin
                                if (stale_q) begin
                                        addr_q  <= br_addr_q;
                                        stale_q <= 1'b0;
                                end else begin
                                        addr_q <= addr_q + WORD_STEP;
                                end
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Response side and FIFO
        ////////////////////////////////////////////////////////////////////////////

        // Discarded responses and flush cycles never reach the FIFO
        assign push  = mem_rsp_i.rvalid && (disc_cnt_q == '0) && !branch;
        assign valid = (fifo_cnt_q != '0) && !branch;
        assign pop   = valid && fetch_ctrl_i.fetch_ready;

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        fifo_cnt_q <= '0;
                        rd_ptr_q   <= '0;
                        wr_ptr_q   <= '0;
                end else if (branch) begin
                        fifo_cnt_q <= '0;
                        rd_ptr_q   <= '0;
                        wr_ptr_q   <= '0;
                end else begin
                        fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
                        if (push) begin
                                wr_ptr_q <= ptr_next(wr_ptr_q);
                        end
                        if (pop) begin
                                rd_ptr_q <= ptr_next(rd_ptr_q);
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (push) begin
                        fifo_mem[wr_ptr_q] <= mem_rsp_i.rdata;
                end
                if (branch) begin
                        br_addr_q <= fetch_ctrl_i.branch_addr;
                end
        end

        assign mem_req_o.req  = req;
        assign mem_req_o.addr = addr_q;

        // rdata reads as zero when nothing is offered
        assign fetch_o.valid = valid;
        assign fetch_o.rdata = valid ? fifo_mem[rd_ptr_q] : '0;
        assign fetch_o.busy  = (out_cnt_q != '0) || (fifo_cnt_q != '0);

endmodule

//--- prefetch_buffer_tmr.f
+incdir+.
prefetch_buffer_tmr_pkg.sv
prefetch_buffer_core.sv
tmr_voter.sv
fault_monitor.sv
prefetch_buffer_tmr.sv
prefetch_buffer_tmr_asserts.sv
prefetch_buffer_tmr_tb.sv

//--- prefetch_buffer_tmr.sv
/*
 * Triplicated prefetch buffer with voted outputs.
 * Core control is shared; each replica has its own memory response.
 * Broken replicas are dropped from the vote until reset.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module prefetch_buffer_tmr (
        input  logic                                                 clk,
        input  logic                                                 rst_i,
        input  prefetch_buffer_tmr_pkg::fetch_ctrl_t                 fetch_ctrl_i,
        input  prefetch_buffer_tmr_pkg::mem_rsp_t [`PF_N_REPL-1:0]   mem_rsp_i,
        input  prefetch_buffer_tmr_pkg::repl_vec_t                   set_broken_i,
        output prefetch_buffer_tmr_pkg::fetch_out_t                  fetch_o,
        output prefetch_buffer_tmr_pkg::mem_req_t                    mem_req_o,
        output prefetch_buffer_tmr_pkg::repl_vec_t                   is_broken_o,
        output logic                                                 err_detected_o,
        output logic                                                 err_corrected_o
);
        import prefetch_buffer_tmr_pkg::*;

        // Replica outputs before voting
        fetch_out_t fetch_copy [`PF_N_REPL];
        mem_req_t   req_copy   [`PF_N_REPL];

        // Voter reports
        repl_vec_t out_block_err;
        repl_vec_t req_block_err;
        logic      out_detected;
        logic      out_corrected;
        logic      req_detected;
        logic      req_corrected;

        for (genvar g = 0; g < `PF_N_REPL; g++) begin : g_repl
                prefetch_buffer_core u_core (
                        .clk          (clk),
                        .rst_i        (rst_i),
                        .fetch_ctrl_i (fetch_ctrl_i),
                        .mem_rsp_i    (mem_rsp_i[g]),
                        .fetch_o      (fetch_copy[g]),
                        .mem_req_o    (req_copy[g])
                );
        end

        tmr_voter #(.T(fetch_out_t)) u_out_voter (
                .to_vote_i       (fetch_copy),
                .broken_i        (is_broken_o),
                .voted_o         (fetch_o),
                .block_err_o     (out_block_err),
                .err_detected_o  (out_detected),
                .err_corrected_o (out_corrected)
        );

        tmr_voter #(.T(mem_req_t)) u_req_voter (
                .to_vote_i       (req_copy),
                .broken_i        (is_broken_o),
                .voted_o         (mem_req_o),
                .block_err_o     (req_block_err),
                .err_detected_o  (req_detected),
                .err_corrected_o (req_corrected)
        );

        fault_monitor u_fault_monitor (
                .clk             (clk),
                .rst_i           (rst_i),
                .out_block_err_i (out_block_err),
                .req_block_err_i (req_block_err),
                .out_detected_i  (out_detected),
                .out_corrected_i (out_corrected),
                .req_detected_i  (req_detected),
                .req_corrected_i (req_corrected),
                .set_broken_i    (set_broken_i),
                .is_broken_o     (is_broken_o),
                .err_detected_o  (err_detected_o),
                .err_corrected_o (err_corrected_o)
        );

endmodule

//--- prefetch_buffer_tmr_asserts.sv
/*
 * Concurrent checks bound into the triplicated prefetch buffer.
 * Assumes all replicas see the same gnt and rvalid; only rdata may differ.
 * Assumes memory answers every grant, in order.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module prefetch_buffer_tmr_asserts (
        input logic                                               clk,
        input logic                                               rst_i,
        input prefetch_buffer_tmr_pkg::fetch_ctrl_t               fetch_ctrl_i,
        input prefetch_buffer_tmr_pkg::mem_rsp_t [`PF_N_REPL-1:0] mem_rsp_i,
        input prefetch_buffer_tmr_pkg::repl_vec_t                 set_broken_i,
        input prefetch_buffer_tmr_pkg::fetch_out_t                fetch_o,
        input prefetch_buffer_tmr_pkg::mem_req_t                  mem_req_o,
        input prefetch_buffer_tmr_pkg::repl_vec_t                 is_broken_o,
        input logic                                               err_detected_o,
        input logic                                               err_corrected_o,
        input prefetch_buffer_tmr_pkg::repl_vec_t                 blame_i,
        input prefetch_buffer_tmr_pkg::fetch_out_t                fetch_copy_i [`PF_N_REPL],
        input prefetch_buffer_tmr_pkg::mem_req_t                  req_copy_i [`PF_N_REPL]
);
        import prefetch_buffer_tmr_pkg::*;

        int unsigned           fail_cnt = 0;
        logic                  started_q;
        logic                  skip_q;
        logic                  split_q;
        logic [`PF_ADDR_W-1:0] exp_data_q;
        logic [`PF_ADDR_W-1:0] exp_req_q;
        int unsigned           live_gnt_q;
        logic                  gnt;
        logic                  xfer;
        logic                  live_gnt;
        logic                  copy_split;

        task automatic record_failure(input string msg);
                fail_cnt++;
                $error("%s", msg);
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Expected fetch stream
        ////////////////////////////////////////////////////////////////////////////

        assign gnt      = mem_req_o.req && mem_rsp_i[0].gnt;
        assign xfer     = fetch_o.valid && fetch_ctrl_i.fetch_ready;
        // A request left pending across a branch is granted once and then dropped
        assign live_gnt = gnt && !fetch_ctrl_i.branch && !skip_q;

        // Raw replica outputs that do not all agree
        assign copy_split = (fetch_copy_i[0] != fetch_copy_i[1])
                            || (fetch_copy_i[0] != fetch_copy_i[2])
                            || (req_copy_i[0] != req_copy_i[1])
                            || (req_copy_i[0] != req_copy_i[2]);

        always_ff @(posedge clk) begin
                if (rst_i) begin
                        started_q  <= 1'b0;
                        skip_q     <= 1'b0;
                        split_q    <= 1'b0;
                        exp_data_q <= '0;
                        exp_req_q  <= '0;
                        live_gnt_q <= 0;
                end else begin
                        // Healthy replicas 0 and 2 stay in step while their inputs match
                        if (mem_rsp_i[0] != mem_rsp_i[2]) begin
                                split_q <= 1'b1;
                        end
                        if (fetch_ctrl_i.branch) begin
                                started_q  <= 1'b1;
                                skip_q     <= mem_req_o.req && !mem_rsp_i[0].gnt;
                                exp_data_q <= fetch_ctrl_i.branch_addr;
                                exp_req_q  <= fetch_ctrl_i.branch_addr;
                                live_gnt_q <= 0;
                        end else begin
                                if (gnt) begin
                                        skip_q <= 1'b0;
                                end
                                if (xfer) begin
                                        exp_data_q <= exp_data_q + 32'd4;
                                end
                                if (live_gnt) begin
                                        exp_req_q <= exp_req_q + 32'd4;
                                end
                                live_gnt_q <= (xfer ? 0 : live_gnt_q) + int'(live_gnt);
                        end
                end
        end

        a_idle: assert property (@(posedge clk) disable iff (rst_i)
                !started_q |-> fetch_o == '0 && !mem_req_o.req && is_broken_o == '0
                               && !err_detected_o && !err_corrected_o)
                else record_failure("Output active before the first branch");
        a_data: assert property (@(posedge clk) disable iff (rst_i)
                xfer |-> fetch_o.rdata == exp_data_q)
                else record_failure("Delivered instruction is not the expected word");
        a_req_addr: assert property (@(posedge clk) disable iff (rst_i)
                live_gnt |-> mem_req_o.addr == exp_req_q)
                else record_failure("Granted address out of sequence");
        a_req_hold: assert property (@(posedge clk) disable iff (rst_i)
                mem_req_o.req && !mem_rsp_i[0].gnt |=> mem_req_o.req && $stable(mem_req_o.addr))
                else record_failure("Request dropped or changed before grant");
        a_fetch_hold: assert property (@(posedge clk) disable iff (rst_i)
                fetch_o.valid && !fetch_ctrl_i.fetch_ready ##1 !fetch_ctrl_i.branch
                |-> fetch_o.valid && $stable(fetch_o.rdata))
                else record_failure("Offered instruction changed under back-pressure");
        a_room: assert property (@(posedge clk) disable iff (rst_i)
                live_gnt_q <= `PF_FIFO_DEPTH)
                else record_failure("Too many grants without a delivery");
        a_busy_stored: assert property (@(posedge clk) disable iff (rst_i)
                fetch_o.valid |-> fetch_o.busy)
                else record_failure("Busy low while an instruction is offered");
        a_busy_issued: assert property (@(posedge clk) disable iff (rst_i)
                gnt |=> fetch_o.busy)
                else record_failure("Busy low after a granted request");
        a_flags: assert property (@(posedge clk) disable iff (rst_i)
                is_broken_o == '0 && copy_split |-> err_detected_o && err_corrected_o)
                else record_failure("Disagreement not flagged as detected and corrected");
        a_masked: assert property (@(posedge clk) disable iff (rst_i)
                is_broken_o == 3'b010 && !split_q |-> !err_detected_o)
                else record_failure("Broken replica 1 still raises detected");

        for (genvar r = 0; r < `PF_N_REPL; r++) begin : g_repl_chk
                a_count: assert property (@(posedge clk) disable iff (rst_i)
                        blame_i[r] [*3] |=> is_broken_o[r])
                        else record_failure("Replica not broken after three error cycles");
                a_sticky: assert property (@(posedge clk) disable iff (rst_i)
                        set_broken_i[r] || is_broken_o[r] |=> is_broken_o[r])
                        else record_failure("Broken flag missing or cleared");
        end

endmodule

bind prefetch_buffer_tmr prefetch_buffer_tmr_asserts u_asserts (
        .*,
        .blame_i      (out_block_err | req_block_err),
        .fetch_copy_i (fetch_copy),
        .req_copy_i   (req_copy)
);

//--- prefetch_buffer_tmr_params.svh
/*
 * Shared constants for the triplicated prefetch buffer.
 * The voter and monitor logic assume PF_N_REPL is 3.
 * FT_THRESHOLD must fit in FT_COUNT_W bits.
 */

`ifndef PREFETCH_BUFFER_TMR_PARAMS_SVH
`define PREFETCH_BUFFER_TMR_PARAMS_SVH

// Datapath widths
`define PF_ADDR_W 32
`define PF_DATA_W 32

// Words held in the FIFO plus requests in flight, per replica
`define PF_FIFO_DEPTH 2

// Number of redundant replicas
`define PF_N_REPL 3

// Leaky error counter, one per replica
`define FT_INCREMENT 4
`define FT_DECREMENT 1
`define FT_THRESHOLD 12
`define FT_COUNT_W 5

`endif

//--- prefetch_buffer_tmr_pkg.sv
/*
 * Bundle types for the triplicated prefetch buffer.
 * Widths come from the shared parameter header.
 */

`include "prefetch_buffer_tmr_params.svh"

package prefetch_buffer_tmr_pkg;

        // Core side control, shared by all replicas
        typedef struct packed {
                logic                  req;
                logic                  branch;
                logic [`PF_ADDR_W-1:0] branch_addr;
                logic                  fetch_ready;
        } fetch_ctrl_t;

        // Memory response, one copy per replica
        typedef struct packed {
                logic                  gnt;
                logic                  rvalid;
                logic [`PF_DATA_W-1:0] rdata;
        } mem_rsp_t;

        // Memory request, voted before it leaves the block
        typedef struct packed {
                logic                  req;
                logic [`PF_ADDR_W-1:0] addr;
        } mem_req_t;

        // Instruction handed to the core
        typedef struct packed {
                logic                  valid;
                logic [`PF_DATA_W-1:0] rdata;
                logic                  busy;
        } fetch_out_t;

        // One flag per replica
        typedef logic [`PF_N_REPL-1:0] repl_vec_t;

endpackage

//--- prefetch_buffer_tmr_tb.sv
/*
 * Drives the triplicated prefetch buffer against a random-latency memory.
 * All checks sit in the bound assertion module.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module prefetch_buffer_tmr_tb;
        import prefetch_buffer_tmr_pkg::*;

        // Several times the length of the stimulus sequence
        localparam int MAX_CYCLES = 2000;

        logic                      clk;
        logic                      rst_i;
        fetch_ctrl_t               fetch_ctrl;
        mem_rsp_t [`PF_N_REPL-1:0] mem_rsp;
        mem_rsp_t [`PF_N_REPL-1:0] mem_rsp_nxt;
        repl_vec_t                 set_broken;
        fetch_out_t                fetch;
        mem_req_t                  mem_req;
        repl_vec_t                 is_broken;
        logic                      err_detected;
        logic                      err_corrected;
        integer                    seed;
        int unsigned               cycle_cnt;
        int unsigned               delivered;
        logic [`PF_ADDR_W-1:0]     pend_addr [$];
        int unsigned               pend_due [$];
        logic [`PF_ADDR_W-1:0]     bad_addr;
        repl_vec_t                 bad_mask;
        logic [`PF_DATA_W-1:0]     word;
        logic                      gnt_nxt;
        logic                      rv_nxt;

        prefetch_buffer_tmr DUT (
                .clk             (clk),
                .rst_i           (rst_i),
                .fetch_ctrl_i    (fetch_ctrl),
                .mem_rsp_i       (mem_rsp),
                .set_broken_i    (set_broken),
                .fetch_o         (fetch),
                .mem_req_o       (mem_req),
                .is_broken_o     (is_broken),
                .err_detected_o  (err_detected),
                .err_corrected_o (err_corrected)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
                #2;
                mem_rsp = mem_rsp_nxt;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Memory model, sampled mid-cycle where all handshakes have settled
        ////////////////////////////////////////////////////////////////////////////

        always @(negedge clk) begin
                if (!rst_i && mem_req.req && mem_rsp[0].gnt) begin
                        pend_addr.push_back(mem_req.addr);
                        pend_due.push_back(cycle_cnt + 1 + (($random(seed) & 32'hff) % 3));
                end
                if (mem_rsp[0].rvalid) begin
                        void'(pend_addr.pop_front());
                        void'(pend_due.pop_front());
                end
                gnt_nxt = (($random(seed) & 32'h3) != 0);
                rv_nxt  = (pend_due.size() != 0) && (pend_due[0] <= cycle_cnt + 1);
                word    = rv_nxt ? pend_addr[0] : '0;
                for (int r = 0; r < `PF_N_REPL; r++) begin
                        mem_rsp_nxt[r].gnt    = gnt_nxt;
                        mem_rsp_nxt[r].rvalid = rv_nxt;
                        // Only the selected replicas see the flipped word
                        mem_rsp_nxt[r].rdata  = (rv_nxt && bad_mask[r] && word == bad_addr)
                                                ? ~word : word;
                end
        end

        always @(negedge clk) begin
                if (fetch.valid && fetch_ctrl.fetch_ready) begin
                        delivered++;
                end
                if (DUT.u_asserts.fail_cnt != 0) begin
                        $display("[ERROR] %0t: a bound assertion failed, see above", $time);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "Stopped at the first failed check");
                end else if (cycle_cnt >= MAX_CYCLES) begin
                        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "Cycle limit reached");
                end
        end

        task automatic step();
                @(posedge clk);
                #2;
        endtask

        task automatic branch_to(input logic [`PF_ADDR_W-1:0] addr);
                fetch_ctrl.branch      = 1'b1;
                fetch_ctrl.branch_addr = addr;
                fetch_ctrl.req         = 1'b1;
                step();
                fetch_ctrl.branch = 1'b0;
        endtask

        task automatic wait_deliveries(input int unsigned n);
                int unsigned target;
                target = delivered + n;
                while (delivered < target) begin
                        step();
                end
        endtask

        initial begin
                seed        = 32'h4246;
                cycle_cnt   = 0;
                delivered   = 0;
                rst_i       = 1'b1;
                fetch_ctrl  = '0;
                set_broken  = '0;
                mem_rsp     = '0;
                mem_rsp_nxt = '0;
                bad_addr    = '0;
                bad_mask    = '0;
                repeat (10) @(posedge clk);
                #2;
                rst_i = 1'b0;
                // Idle until the first branch
                repeat (5) step();
                fetch_ctrl.fetch_ready = 1'b1;
                branch_to(32'h0000_1000);
                wait_deliveries(10);
                // Back-pressure, then a branch with responses in flight
                fetch_ctrl.fetch_ready = 1'b0;
                repeat (12) step();
                fetch_ctrl.fetch_ready = 1'b1;
                wait_deliveries(3);
                branch_to(32'h0000_2040);
                wait_deliveries(8);
                fetch_ctrl.req = 1'b0;
                repeat (8) step();
                fetch_ctrl.req = 1'b1;
                wait_deliveries(4);
                // Single bad word on replica 1, outvoted
                bad_addr = 32'h0000_300c;
                bad_mask = 3'b010;
                branch_to(32'h0000_3000);
                wait_deliveries(8);
                bad_mask = '0;
                // Bad word held at the head until replica 1 is marked broken
                fetch_ctrl.fetch_ready = 1'b0;
                bad_addr = 32'h0000_4000;
                bad_mask = 3'b010;
                branch_to(32'h0000_4000);
                while (!is_broken[1]) begin
                        step();
                end
                fetch_ctrl.fetch_ready = 1'b1;
                bad_addr = 32'h0000_4020;
                wait_deliveries(12);
                bad_mask = '0;
                // Forced breakage of replica 2
                set_broken = 3'b100;
                step();
                set_broken = '0;
                wait_deliveries(8);
                branch_to(32'h0000_5000);
                wait_deliveries(6);
                repeat (4) step();
                if (DUT.u_asserts.fail_cnt == 0) begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end else begin
                        $display("[ERROR] %0t: a bound assertion failed, see above", $time);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "Run ended with a failed check");
                end
        end

endmodule

//--- tmr_voter.sv
/*
 * Three way voter for any packed payload type.
 * With one replica broken the lower healthy copy wins and a mismatch
 * is only detected, not corrected or blamed on a replica.
 */

`timescale 1ns/1ps

`include "prefetch_buffer_tmr_params.svh"

module tmr_voter #(
        parameter type T = logic
) (
        input  T                                   to_vote_i [`PF_N_REPL],
        input  prefetch_buffer_tmr_pkg::repl_vec_t broken_i,
        output T                                   voted_o,
        output prefetch_buffer_tmr_pkg::repl_vec_t block_err_o,
        output logic                               err_detected_o,
        output logic                               err_corrected_o
);
        import prefetch_buffer_tmr_pkg::*;

        localparam int W = $bits(T);

        logic [W-1:0] v0;
        logic [W-1:0] v1;
        logic [W-1:0] v2;
        logic [W-1:0] maj;
        logic [W-1:0] sel;

        assign v0 = to_vote_i[0];
        assign v1 = to_vote_i[1];
        assign v2 = to_vote_i[2];

        // Bitwise majority of all three copies
        assign maj = (v0 & v1) | (v0 & v2) | (v1 & v2);

        always_comb begin
                sel             = maj;
                block_err_o     = '0;
                err_detected_o  = 1'b0;
                err_corrected_o = 1'b0;
                case (broken_i)
                        3'b000: begin
                                block_err_o     = {v2 != maj, v1 != maj, v0 != maj};
                                err_detected_o  = |block_err_o;
                                err_corrected_o = |block_err_o;
                        end
                        3'b001: begin
                                sel            = v1;
                                err_detected_o = (v1 != v2);
                        end
                        3'b010: begin
                                sel            = v0;
                                err_detected_o = (v0 != v2);
                        end
                        3'b100: begin
                                sel            = v0;
                                err_detected_o = (v0 != v1);
                        end
                        default: begin
                                // Two or more broken, nothing left to compare
                                if (!broken_i[0]) begin
                                        sel = v0;
                                end else if (!broken_i[1]) begin
                                        sel = v1;
                                end else if (!broken_i[2]) begin
                                        sel = v2;
                                end else begin
                                        sel = v0;
                                end
                        end
                endcase
        end

        assign voted_o = T'(sel);

endmodule
